// File: design/chan_writer.sv
`default_nettype none
`timescale 1ns/1ps

`include "vid_rx_cfg.svh"

module chan_writer #(
    parameter int CHAN = 0  // channel index, picks the tap direction
) (
    input  logic                  ch_clk,
    input  logic                  rst_n,
    input  vid_rx_pkg::line_ctl_t ctl,
    input  logic [`VR_PIX_W-1:0]  pix,
    output vid_rx_pkg::wr_req_t   wr
);

    // ==================================================================
    // direction, fixed at elaboration
    // ==================================================================
    // a single channel never counts down in split mode
    localparam bit REVERSE = (`VR_HEAD_DIR == 1) ||
                             ((`VR_HEAD_DIR == 2) && (`VR_NUM_CHAN > 1) &&
                              (CHAN >= `VR_NUM_CHAN / 2));

    logic [`VR_ADDR_W:0]   width_m1;
    logic [`VR_ADDR_W-1:0] start_addr;  // first address of a line
    logic [`VR_ADDR_W-1:0] cur_addr;    // address for this cycle
    logic [`VR_ADDR_W-1:0] addr_cnt;
    logic                  we_q;
    logic                  bank_q;
    logic [`VR_ADDR_W-1:0] addr_q;
    logic [`VR_PIX_W-1:0]  pix_q;

    assign width_m1   = ctl.width - 1'b1;
    assign start_addr = REVERSE ? width_m1[`VR_ADDR_W-1:0] : '0;

    // line_start and win coincide when col_start is 0
    assign cur_addr = ctl.line_start ? start_addr : addr_cnt;

    // ==================================================================
    // address counter
    // ==================================================================
    always_ff @(posedge ch_clk) begin
        if (!rst_n) begin
            we_q     <= 1'b0;
            addr_cnt <= '0;
        end else begin
            we_q <= ctl.win;
            if (ctl.win) begin
                // step past the word written this cycle
                addr_cnt <= REVERSE ? cur_addr - 1'b1 : cur_addr + 1'b1;
            end else if (ctl.line_start) begin
                addr_cnt <= start_addr;  // window opens later in the line
            end
        end
    end

    // write payload
    always_ff @(posedge ch_clk) begin
        addr_q <= cur_addr;
        bank_q <= ctl.bank;  // passed straight through
        pix_q  <= pix;
    end

    assign wr = '{we:   we_q,
                  bank: bank_q,
                  addr: addr_q,
                  pix:  pix_q};

endmodule

`default_nettype wire

// File: design/line_ram_bank.sv
`default_nettype none
`timescale 1ns/1ps

`include "vid_rx_cfg.svh"

module line_ram_bank (
    input  logic                                   ch_clk,
    input  vid_rx_pkg::wr_req_t [`VR_NUM_CHAN-1:0] wr,
    input  vid_rx_pkg::rd_req_t                    rd,
    output logic [`VR_PIX_W-1:0]                   rd_data
);

    // per channel word at the read address
    logic [`VR_NUM_CHAN-1:0][`VR_PIX_W-1:0] rd_word;

    // ==================================================================
    // ping-pong storage, one pair of banks per channel
    // ==================================================================
    for (genvar c = 0; c < `VR_NUM_CHAN; c++) begin : g_ram

        // [bank][word]
        logic [`VR_PIX_W-1:0] mem [2][`VR_RAM_DEPTH];

        // all channels write in parallel, addresses past the depth dropped
        always_ff @(posedge ch_clk) begin
            if (wr[c].we && (wr[c].addr < `VR_RAM_DEPTH)) begin
                mem[wr[c].bank][wr[c].addr] <= wr[c].pix;
            end
        end

        assign rd_word[c] = mem[rd.bank][rd.addr];  // bank and word select

    end

    // ==================================================================
    // read port
    // ==================================================================
    // channel select, registered, data one cycle after rd
    always_ff @(posedge ch_clk) begin
        rd_data <= rd_word[rd.chan];
    end

endmodule

`default_nettype wire

// File: design/rx_timing.sv
`default_nettype none
`timescale 1ns/1ps

`include "vid_rx_cfg.svh"

module rx_timing (
    input  logic                                    ch_clk,
    input  logic                                    rst_n,
    input  logic                                    hblank_in,
    input  logic                                    vblank_in,
    input  logic                                    active_video_in,
    input  vid_rx_pkg::win_cfg_t                    win,
    input  logic [`VR_NUM_CHAN-1:0][`VR_PIX_W-1:0]  pix_in,
    output vid_rx_pkg::line_ctl_t                   ctl,
    output logic [`VR_NUM_CHAN-1:0][`VR_PIX_W-1:0]  pix_d,
    output vid_rx_pkg::line_stat_t                  stat
);
    import vid_rx_pkg::*;

    rx_state_e            cur_state;
    rx_state_e            next_state;
    logic                 active_d;     // history for edge detect
    logic                 hblank_d;
    logic                 act_rise;
    logic                 hblank_rise;
    logic                 line_end;     // falling edge of active video
    logic [`VR_CNT_W-1:0] col_cnt;      // column of current active sample
    logic [`VR_CNT_W-1:0] row_cnt;
    logic [`VR_CNT_W-1:0] row_now;
    logic [`VR_CNT_W-1:0] active_len;
    logic [`VR_CNT_W-1:0] per_cnt;      // cycles since last hblank rise
    logic [`VR_CNT_W-1:0] line_len;
    logic [`VR_CNT_W-1:0] crop_w;
    logic                 row_hit;
    logic                 col_hit;
    logic                 win_now;
    logic                 line_hit;     // this line touched the window
    logic                 bank_flag;
    logic                 frame_end_q;
    logic                 frame_done;

    // ==================================================================
    // sync edges and frame fsm
    // ==================================================================
    always_ff @(posedge ch_clk) begin
        if (!rst_n) begin
            active_d <= 1'b0;
            hblank_d <= 1'b1;  // no fake rise out of reset
        end else begin
            active_d <= active_video_in;
            hblank_d <= hblank_in;
        end
    end

    assign act_rise    = active_video_in && !active_d;
    assign hblank_rise = hblank_in && !hblank_d;
    assign line_end    = (cur_state == ST_REC) && !active_video_in;

    always_comb begin
        next_state = cur_state;
        case (cur_state)
            ST_IDLE: begin
                if (active_video_in) next_state = ST_REC;
            end
            ST_REC: begin
                if (!active_video_in) next_state = vblank_in ? ST_IDLE : ST_NXT;  // vblank ends frame
            end
            ST_NXT: begin
                if (active_video_in) next_state = ST_REC;
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge ch_clk) begin
        if (!rst_n) cur_state <= ST_IDLE;
        else        cur_state <= next_state;
    end

    // ==================================================================
    // counters and measurements
    // ==================================================================
    // first line of a new frame is row 0 even before row_cnt clears
    assign row_now = (cur_state == ST_IDLE) ? '0 : row_cnt;

    always_ff @(posedge ch_clk) begin
        if (!rst_n) begin
            col_cnt    <= '0;
            row_cnt    <= '0;
            active_len <= '0;
        end else begin
            if (active_video_in) col_cnt <= col_cnt + 1'b1;
            else                 col_cnt <= '0;  // ready for next line
            if (line_end) begin
                active_len <= col_cnt;           // count of active cycles
                row_cnt    <= row_cnt + 1'b1;
            end else if (cur_state == ST_IDLE && active_video_in) begin
                row_cnt <= '0;                   // new frame, keep last count until now
            end
        end
    end

    // line period, hblank rise to rise
    always_ff @(posedge ch_clk) begin
        if (!rst_n) begin
            per_cnt  <= '0;
            line_len <= '0;
        end else if (hblank_rise) begin
            line_len <= per_cnt;
            per_cnt  <= 1;
        end else begin
            per_cnt <= per_cnt + 1'b1;
        end
    end

    // ==================================================================
    // crop window and bank
    // ==================================================================
    assign row_hit = (row_now >= win.row_start) && (row_now <= win.row_end);
    assign col_hit = (col_cnt >= win.col_start) && (col_cnt <= win.col_end);
    assign win_now = (next_state == ST_REC) && row_hit && col_hit;
    assign crop_w  = win.col_end - win.col_start + 1'b1;

    always_ff @(posedge ch_clk) begin
        if (!rst_n) begin
            line_hit  <= 1'b0;
            bank_flag <= 1'b1;
        end else begin
            if (line_end)     line_hit <= 1'b0;
            else if (win_now) line_hit <= 1'b1;
            if (cur_state == ST_IDLE)     bank_flag <= 1'b1;  // every frame starts on bank 1
            else if (line_end && line_hit) bank_flag <= ~bank_flag;
        end
    end

    always_ff @(posedge ch_clk) begin
        if (!rst_n) begin
            ctl <= '{win: 1'b0, line_start: 1'b0, bank: 1'b1, width: '0};
        end else begin
            ctl <= '{win:        win_now,
                     line_start: act_rise,
                     bank:       bank_flag,
                     width:      crop_w[`VR_ADDR_W:0]};
        end
    end

    always_ff @(posedge ch_clk) begin
        pix_d <= pix_in;  // stays aligned with ctl
    end

    // frame_done one cycle after idle entry
    always_ff @(posedge ch_clk) begin
        if (!rst_n) begin
            frame_end_q <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            frame_end_q <= line_end && vblank_in;
            frame_done  <= frame_end_q;
        end
    end

    assign stat = '{active_len: active_len,
                    line_len:   line_len,
                    row_cnt:    row_cnt,
                    frame_done: frame_done};

endmodule

`default_nettype wire

// File: design/vid_rx_pkg.sv
`default_nettype none

`include "vid_rx_cfg.svh"

package vid_rx_pkg;

    // frame state machine
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // waiting for first line of a frame
        ST_REC  = 2'd1,  // active video
        ST_NXT  = 2'd2   // between lines
    } rx_state_e;

    // crop window, inclusive bounds
    typedef struct packed {
        logic [`VR_CNT_W-1:0] row_start;
        logic [`VR_CNT_W-1:0] row_end;
        logic [`VR_CNT_W-1:0] col_start;
        logic [`VR_CNT_W-1:0] col_end;
    } win_cfg_t;

    // front end -> every writer, one cycle after the input sample
    typedef struct packed {
        logic                 win;         // pixel inside crop window
        logic                 line_start;  // first active cycle of a line
        logic                 bank;        // write bank
        logic [`VR_ADDR_W:0]  width;       // crop width in pixels
    } line_ctl_t;

    // measurements seen from outside
    typedef struct packed {
        logic [`VR_CNT_W-1:0] active_len;  // active cycles, last line
        logic [`VR_CNT_W-1:0] line_len;    // hblank rise to rise
        logic [`VR_CNT_W-1:0] row_cnt;
        logic                 frame_done;  // single pulse
    } line_stat_t;

    // one channel write
    typedef struct packed {
        logic                 we;
        logic                 bank;
        logic [`VR_ADDR_W-1:0] addr;
        logic [`VR_PIX_W-1:0] pix;
    } wr_req_t;

    // external read port
    typedef struct packed {
        logic [$clog2(`VR_NUM_CHAN)-1:0] chan;
        logic                            bank;
        logic [`VR_ADDR_W-1:0]           addr;
    } rd_req_t;

endpackage

`default_nettype wire

// File: design/vid_rx_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "vid_rx_cfg.svh"

module vid_rx_top (
    input  logic                                    ch_clk,
    input  logic                                    rst_n,
    input  logic                                    hblank_in,
    input  logic                                    vblank_in,
    input  logic                                    active_video_in,
    input  vid_rx_pkg::win_cfg_t                    win,
    input  logic [`VR_NUM_CHAN-1:0][`VR_PIX_W-1:0]  pix_in,
    input  vid_rx_pkg::rd_req_t                     rd,
    output vid_rx_pkg::line_stat_t                  stat,
    output logic [`VR_PIX_W-1:0]                    rd_data
);
    import vid_rx_pkg::*;

    line_ctl_t                              ctl;    // broadcast to all writers
    logic [`VR_NUM_CHAN-1:0][`VR_PIX_W-1:0] pix_d;  // pixels aligned with ctl
    wr_req_t [`VR_NUM_CHAN-1:0]             wr;

    // ==================================================================
    // shared timing front end
    // ==================================================================
    rx_timing i_rx_timing (
        .ch_clk          (ch_clk),
        .rst_n           (rst_n),
        .hblank_in       (hblank_in),
        .vblank_in       (vblank_in),
        .active_video_in (active_video_in),
        .win             (win),
        .pix_in          (pix_in),
        .ctl             (ctl),
        .pix_d           (pix_d),
        .stat            (stat)
    );

    // one writer per channel, direction from index
    for (genvar i = 0; i < `VR_NUM_CHAN; i++) begin : g_chan
        chan_writer #(
            .CHAN (i)
        ) i_chan_writer (
            .ch_clk (ch_clk),
            .rst_n  (rst_n),
            .ctl    (ctl),
            .pix    (pix_d[i]),
            .wr     (wr[i])
        );
    end

    // ==================================================================
    // line buffers
    // ==================================================================
    line_ram_bank i_line_ram_bank (
        .ch_clk  (ch_clk),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: include/vid_rx_cfg.svh
`ifndef VID_RX_CFG_SVH
`define VID_RX_CFG_SVH

// ======================================================================
// receiver sizing
// ======================================================================

// channel count and pixel bus
`define VR_NUM_CHAN   4
`define VR_PIX_W      18

// row / column counters
`define VR_CNT_W      10

// line ram, words per bank and address width
`define VR_RAM_DEPTH  100
`define VR_ADDR_W     7

// tap direction
// 0 all forward, 1 all reverse, 2 lower half forward and upper half reverse
`define VR_HEAD_DIR   2

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the video receiver testbench with verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary -j 0 --top-module tb_vid_rx -f vid_rx.f -Mdir "$OBJ" -o vid_rx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/vid_rx_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: test/rx_checker.sv
`default_nettype none
`timescale 1ns/1ps

`include "vid_rx_cfg.svh"

module rx_checker (
    input  logic                                   ch_clk,
    input  logic                                   rst_n,
    input  logic                                   active_video_in,
    input  logic                                   vblank_in,
    input  vid_rx_pkg::win_cfg_t                   win,
    input  logic [`VR_NUM_CHAN-1:0][`VR_PIX_W-1:0] pix_in,
    input  vid_rx_pkg::line_stat_t                 stat,
    input  vid_rx_pkg::rd_req_t                    rd,
    input  logic                                   rd_valid,
    input  logic [`VR_PIX_W-1:0]                   rd_data,
    input  int                                     exp_act,    // active width A
    input  int                                     exp_blank,  // horizontal blank B
    output int                                     err_cnt,
    output int                                     chk_cnt
);
    import vid_rx_pkg::*;

    // expected line buffer contents, [chan][bank][word]
    logic [`VR_PIX_W-1:0] model_mem [`VR_NUM_CHAN][2][`VR_RAM_DEPTH];
    bit                   model_vld [`VR_NUM_CHAN][2][`VR_RAM_DEPTH];
    logic                 act_q;
    bit                   in_frame;
    bit                   line_win;   // current line hit the window
    bit                   meas_pend;  // line ended, stat due after the next edge
    int                   line_idx;
    int                   col_idx;
    int                   win_idx;    // windowed lines so far in this frame
    int                   done_pend;  // frame ends waiting for frame_done
    bit                   rd_pend;
    rd_req_t              rd_q;

    // reference: bank and address of one cropped pixel
    function automatic void expected_slot(input int chan, input int col, input int win_line,
                                          input win_cfg_t w, output int bank, output int addr);
        int  width;
        int  offs;
        bit  rev;
        width = int'(w.col_end) - int'(w.col_start) + 1;
        offs  = col - int'(w.col_start);
        if (`VR_HEAD_DIR == 0)      rev = 1'b0;
        else if (`VR_HEAD_DIR == 1) rev = 1'b1;
        else                        rev = (chan >= `VR_NUM_CHAN / 2);  // upper half reversed
        addr = rev ? width - 1 - offs : offs;
        bank = (win_line % 2 == 0) ? 1 : 0;  // even windowed lines to bank 1
    endfunction

    task automatic check_value(input string what, input int got, input int want);
        chk_cnt++;
        if (got != want) begin
            err_cnt++;
            $display("[FAIL] at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // ==================================================================
    // watch the ports between clock edges
    // ==================================================================
    always @(negedge ch_clk) begin
        int bank;
        int addr;
        if (!rst_n) begin
            in_frame  = 1'b0;
            rd_pend   = 1'b0;
            meas_pend = 1'b0;
            done_pend = 0;
        end else begin
            // read data belongs to the request of the previous cycle
            if (rd_pend && model_vld[rd_q.chan][rd_q.bank][rd_q.addr]) begin
                check_value($sformatf("read chan %0d bank %0d addr %0d",
                                      rd_q.chan, rd_q.bank, rd_q.addr),
                            int'(rd_data), int'(model_mem[rd_q.chan][rd_q.bank][rd_q.addr]));
            end
            rd_pend = rd_valid;
            rd_q    = rd;

            // measurements latch on the edge that samples the fall
            if (meas_pend) begin
                check_value("active_len", int'(stat.active_len), exp_act);
                check_value("row_cnt", int'(stat.row_cnt), line_idx);
                if (line_idx > 1) begin
                    check_value("line_len", int'(stat.line_len), exp_act + exp_blank);
                end
                meas_pend = 1'b0;
            end

            if (active_video_in && !act_q && !in_frame) begin  // first line of a frame
                if (done_pend != 0) begin
                    $display("frame_done never pulsed for the previous frame");
                    err_cnt++;
                end
                done_pend = 0;
                in_frame  = 1'b1;
                line_idx  = 0;
                win_idx   = 0;
            end
            if (active_video_in) begin
                if (!act_q) begin
                    line_win = 1'b0;
                    col_idx  = 0;
                end
                if (line_idx >= int'(win.row_start) && line_idx <= int'(win.row_end) &&
                    col_idx >= int'(win.col_start) && col_idx <= int'(win.col_end)) begin
                    for (int c = 0; c < `VR_NUM_CHAN; c++) begin
                        expected_slot(c, col_idx, win_idx, win, bank, addr);
                        model_mem[c][bank][addr] = pix_in[c];
                        model_vld[c][bank][addr] = 1'b1;
                    end
                    line_win = 1'b1;
                end
                col_idx++;
            end else if (act_q) begin
                // line just ended, dut sees the fall at the next edge
                meas_pend = 1'b1;
                line_idx++;
                if (line_win) win_idx++;
                if (vblank_in) begin
                    in_frame = 1'b0;
                    done_pend++;
                end
            end
            if (stat.frame_done) begin
                if (done_pend == 0) begin
                    $display("frame_done pulsed at %0t without a frame end", $time);
                    err_cnt++;
                end else begin
                    done_pend--;
                end
            end
        end
        act_q = active_video_in;
    end

endmodule

`default_nettype wire

// File: test/tb_vid_rx.sv
`default_nettype none
`timescale 1ns/1ps

`include "vid_rx_cfg.svh"

module tb_vid_rx;
    import vid_rx_pkg::*;

    // ==================================================================
    // one frame per test
    // ==================================================================
    localparam int NUM_TESTS = 5;
    localparam int VBLANK    = 20;  // quiet cycles after read back
    localparam int RD_CYCLES = 2 * `VR_NUM_CHAN * `VR_RAM_DEPTH + 3;
    localparam int ACT_W [NUM_TESTS] = '{40, 64, 30, 50, 100};
    localparam int BLANK [NUM_TESTS] = '{12, 20,  8, 16,  10};
    localparam int LINES [NUM_TESTS] = '{ 6,  5,  6,  4,   3};
    localparam int ROW_S [NUM_TESTS] = '{ 1,  0,  2,  6,   1};  // test 3 misses every row
    localparam int ROW_E [NUM_TESTS] = '{ 4,  2,  3,  9,   1};
    localparam int COL_S [NUM_TESTS] = '{ 5,  0, 10,  0,   0};
    localparam int COL_E [NUM_TESTS] = '{24, 15, 29, 49,  99};  // test 2 ends on last column

    logic                                   ch_clk;
    logic                                   rst_n;
    logic                                   hblank_in;
    logic                                   vblank_in;
    logic                                   active_video_in;
    win_cfg_t                               win;
    logic [`VR_NUM_CHAN-1:0][`VR_PIX_W-1:0] pix_in;
    rd_req_t                                rd;
    logic                                   rd_valid;  // rd carries a real request
    line_stat_t                             stat;
    logic [`VR_PIX_W-1:0]                   rd_data;
    int                                     exp_act;
    int                                     exp_blank;
    int                                     err_cnt;
    int                                     chk_cnt;
    int                                     hard_err;  // missing done pulses
    int                                     seed;

    initial begin
        ch_clk = 1'b0;
        forever #50 ch_clk = ~ch_clk;
    end

    vid_rx_top i_vid_rx_top (
        .ch_clk (ch_clk), .rst_n (rst_n), .hblank_in (hblank_in), .vblank_in (vblank_in),
        .active_video_in (active_video_in), .win (win), .pix_in (pix_in), .rd (rd),
        .stat (stat), .rd_data (rd_data)
    );

    rx_checker i_rx_checker (
        .ch_clk (ch_clk), .rst_n (rst_n), .active_video_in (active_video_in),
        .vblank_in (vblank_in), .win (win), .pix_in (pix_in), .stat (stat), .rd (rd),
        .rd_valid (rd_valid), .rd_data (rd_data), .exp_act (exp_act),
        .exp_blank (exp_blank), .err_cnt (err_cnt), .chk_cnt (chk_cnt)
    );

    // A active cycles then B blank cycles
    task automatic drive_line(input int act, input int blank, input bit last);
        for (int i = 0; i < act; i++) begin
            @(posedge ch_clk);
            #10;
            active_video_in = 1'b1;
            hblank_in       = 1'b0;
            for (int c = 0; c < `VR_NUM_CHAN; c++) begin
                pix_in[c] = (`VR_PIX_W)'($random(seed));
            end
        end
        @(posedge ch_clk);
        #10;
        active_video_in = 1'b0;
        hblank_in       = 1'b1;
        vblank_in       = last;  // vblank at the fall closes the frame
        if (!last) repeat (blank - 1) @(posedge ch_clk);
    endtask

    task automatic wait_frame_done(input int t);
        int n;
        n = 0;
        while (!stat.frame_done && n < 8) begin
            @(negedge ch_clk);
            n++;
        end
        if (!stat.frame_done) begin
            $display("test %0d: frame_done did not arrive after the last line", t);
            hard_err++;
        end
    endtask

    // every word of every bank, checker skips unwritten ones
    task automatic read_back();
        for (int c = 0; c < `VR_NUM_CHAN; c++) begin
            for (int b = 0; b < 2; b++) begin
                for (int a = 0; a < `VR_RAM_DEPTH; a++) begin
                    @(posedge ch_clk);
                    #10;
                    rd.chan  = c[$clog2(`VR_NUM_CHAN)-1:0];
                    rd.bank  = b[0];
                    rd.addr  = a[`VR_ADDR_W-1:0];
                    rd_valid = 1'b1;
                end
            end
        end
        @(posedge ch_clk);
        #10;
        rd_valid = 1'b0;
        repeat (2) @(posedge ch_clk);  // last data reaches the checker
    endtask

    task automatic run_frame(input int t);
        @(posedge ch_clk);
        #10;
        win.row_start = (`VR_CNT_W)'(ROW_S[t]);
        win.row_end   = (`VR_CNT_W)'(ROW_E[t]);
        win.col_start = (`VR_CNT_W)'(COL_S[t]);
        win.col_end   = (`VR_CNT_W)'(COL_E[t]);
        exp_act       = ACT_W[t];
        exp_blank     = BLANK[t];
        for (int l = 0; l < LINES[t]; l++) begin
            drive_line(ACT_W[t], BLANK[t], l == LINES[t] - 1);
        end
        wait_frame_done(t);
        read_back();
        repeat (VBLANK) @(posedge ch_clk);
        #10;
        vblank_in = 1'b0;
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        int errs_before;
        int errs_now;
        seed            = 32'hd02e8d0f;
        rst_n           = 1'b0;
        hblank_in       = 1'b1;
        vblank_in       = 1'b0;
        active_video_in = 1'b0;
        win             = '0;
        pix_in          = '0;
        rd              = '0;
        rd_valid        = 1'b0;
        exp_act         = 0;
        exp_blank       = 0;
        hard_err        = 0;
        repeat (2) @(posedge ch_clk);
        #10;
        rst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = err_cnt + hard_err;
            run_frame(t);
            errs_now = err_cnt + hard_err - errs_before;
            $display("test %0d  A=%0d B=%0d lines=%0d  %s", t, ACT_W[t], BLANK[t], LINES[t],
                     (errs_now == 0) ? "ok" : $sformatf("%0d errors", errs_now));
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, chk_cnt, err_cnt + hard_err);
        if (err_cnt + hard_err == 0 && chk_cnt > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog, all frames plus 20 %
    initial begin
        int total;
        total = 8;  // reset
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += LINES[t] * (ACT_W[t] + BLANK[t]) + 8 + RD_CYCLES + VBLANK + 2;
        end
        #(total * 100 * 12 / 10);
        $display("timeout: the frames did not complete within %0d cycles", total * 12 / 10);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vid_rx.f
+incdir+include
design/vid_rx_pkg.sv
design/rx_timing.sv
design/chan_writer.sv
design/line_ram_bank.sv
design/vid_rx_top.sv
test/rx_checker.sv
test/tb_vid_rx.sv
